/* source/cp0_consts.svh */
// Register numbers, ExcCode values, reset values and write masks of the CP0 core
// Included by every module that decodes register numbers or cause codes

`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

`default_nettype none

`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14

`define EXC_CODE_INT  5'd0
`define EXC_CODE_ADEL 5'd4   // Load or fetch
`define EXC_CODE_ADES 5'd5
`define EXC_CODE_SYS  5'd8
`define EXC_CODE_BP   5'd9
`define EXC_CODE_RI   5'd10
`define EXC_CODE_CPU  5'd11
`define EXC_CODE_OV   5'd12
`define EXC_CODE_TR   5'd13

// BEV only
`define STATUS_RESET   32'h0040_0000
`define STATUS_WR_MASK 32'h1040_FF17   // CU0 BEV IM UM ERL EXL IE
`define CAUSE_WR_MASK  32'h0000_0300   // IP1_0

`default_nettype wire

`endif

/* source/cp0Pkg.sv */
// Types shared by the CP0 exception and timer core
// Imported by each module for its event, command and register layouts

`default_nettype none

package cp0Pkg;

    typedef enum logic [4:0] {
        excNone,
        excRefetch,
        excInterrupt,
        excFetchAddrErr,
        excLoadAddrErr,
        excStoreAddrErr,
        excSyscall,
        excBreakpoint,
        excReservedInstr,
        excCopUnusable,
        excOverflow,
        excTrap,
        excEret
    } excKind_e;

    typedef struct packed {
        excKind_e    kind;
        logic [31:0] pc;
        logic        inDelaySlot;
        logic [31:0] dataAddr;
    } excEvent_t;

    typedef struct packed {
        logic        enter;
        logic        eret;
        logic        epcLoad;
        logic [31:0] epcValue;
        logic        bdValue;
        logic        codeLoad;
        logic [4:0]  excCode;
        logic        ceLoad;
        logic        badVAddrLoad;
        logic [31:0] badVAddrValue;
    } excCommit_t;

    typedef struct packed {
        logic        status;
        logic        cause;
        logic        count;
        logic        compare;
        logic        epc;
        logic [31:0] data;   // Already masked per target
    } regWrite_t;

    typedef struct packed {
        logic [2:0] rsvd31;
        logic       cu0;
        logic [4:0] rsvd27;
        logic       bev;
        logic [5:0] rsvd21;
        logic [7:0] im;
        logic [2:0] rsvd7;
        logic       um;
        logic       rsvd3;
        logic       erl;
        logic       exl;
        logic       ie;
    } statusReg_t;

    typedef struct packed {
        logic        bd;
        logic        ti;
        logic [1:0]  ce;
        logic [11:0] rsvd27;
        logic [5:0]  ip7to2;
        logic [1:0]  ip1to0;
        logic        rsvd7;
        logic [4:0]  excCode;
        logic [1:0]  rsvd1;
    } causeReg_t;

    // One register word, seen either way
    typedef union packed {
        logic [31:0] raw;
        statusReg_t  status;
        causeReg_t   cause;
    } cp0Word_u;

    typedef struct packed {
        logic        bev;
        logic [7:0]  im;
        logic        exl;
        logic        ie;
        logic [7:0]  ip;   // IP7_2 above IP1_0
        logic [31:0] epc;
    } cp0View_t;

endpackage

`default_nettype wire

/* source/cp0ApbPort.sv */
// APB slave for software access to the CP0 registers
// Decodes paddr[6:2] into write strobes and selects the read word

`include "cp0_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module cp0ApbPort
    import cp0Pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  cp0Word_u    statusWord,
    input  cp0Word_u    causeWord,
    input  logic [31:0] epc,
    input  logic [31:0] badVAddr,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output regWrite_t   regWrite
);

    logic [4:0]  regNum;
    logic        setup;
    logic        access;
    logic        mapped;
    logic        readOnly;
    logic        wrValidQ;   // Setup cycle saw a legal write
    logic        errQ;
    logic [31:0] rdData;
    cp0Word_u    wrWord;

    assign regNum = paddr[6:2];
    assign setup  = psel & ~penable;
    assign access = psel & penable;

    always_comb begin
        mapped    = 1'b1;
        readOnly  = 1'b0;
        rdData    = '0;
        wrWord.raw = pwdata;
        case (regNum)
            `CP0_REG_STATUS: begin
                rdData     = statusWord.raw;
                wrWord.raw = pwdata & `STATUS_WR_MASK;
            end
            `CP0_REG_CAUSE: begin
                rdData     = causeWord.raw;
                wrWord.raw = pwdata & `CAUSE_WR_MASK;
            end
            `CP0_REG_EPC:     rdData = epc;
            `CP0_REG_COUNT:   rdData = count;
            `CP0_REG_COMPARE: rdData = compare;
            `CP0_REG_BADVADDR: begin
                rdData   = badVAddr;
                readOnly = 1'b1;
            end
            default: mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrValidQ <= 1'b0;
            errQ     <= 1'b0;
        end else begin
            wrValidQ <= setup & pwrite & mapped & ~readOnly;
            errQ     <= setup & (~mapped | (pwrite & readOnly));
        end
    end

    // Strobes live only in the access cycle
    always_comb begin
        regWrite.status  = access & wrValidQ & (regNum == `CP0_REG_STATUS);
        regWrite.cause   = access & wrValidQ & (regNum == `CP0_REG_CAUSE);
        regWrite.count   = access & wrValidQ & (regNum == `CP0_REG_COUNT);
        regWrite.compare = access & wrValidQ & (regNum == `CP0_REG_COMPARE);
        regWrite.epc     = access & wrValidQ & (regNum == `CP0_REG_EPC);
        regWrite.data    = wrWord.raw;
    end

    assign pready  = access;   // No wait states
    assign pslverr = access & errQ;
    assign prdata  = rdData;

endmodule

`default_nettype wire

/* source/cp0ExcCtrl.sv */
// Exception classifier of the CP0 core
// Turns one pipeline event per cycle into commit commands for the datapaths

`include "cp0_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module cp0ExcCtrl
    import cp0Pkg::*;
(
    input  excEvent_t  excEvent,
    input  logic       exl,
    output excCommit_t commit
);

    logic enter;

    assign enter = (excEvent.kind != excNone) && (excEvent.kind != excRefetch) &&
                   (excEvent.kind != excEret);

    always_comb begin
        commit          = '0;
        commit.enter    = enter;
        commit.eret     = excEvent.kind == excEret;
        // Nested exceptions keep the first EPC and BD
        commit.epcLoad  = enter & ~exl;
        commit.epcValue = excEvent.inDelaySlot ? excEvent.pc - 32'd4 : excEvent.pc;
        commit.bdValue  = excEvent.inDelaySlot;
        commit.codeLoad = enter;
        commit.ceLoad   = excEvent.kind == excCopUnusable;

        case (excEvent.kind)
            excInterrupt:     commit.excCode = `EXC_CODE_INT;
            excFetchAddrErr:  commit.excCode = `EXC_CODE_ADEL;
            excLoadAddrErr:   commit.excCode = `EXC_CODE_ADEL;
            excStoreAddrErr:  commit.excCode = `EXC_CODE_ADES;
            excSyscall:       commit.excCode = `EXC_CODE_SYS;
            excBreakpoint:    commit.excCode = `EXC_CODE_BP;
            excReservedInstr: commit.excCode = `EXC_CODE_RI;
            excCopUnusable:   commit.excCode = `EXC_CODE_CPU;
            excOverflow:      commit.excCode = `EXC_CODE_OV;
            excTrap:          commit.excCode = `EXC_CODE_TR;
            default:          commit.excCode = `EXC_CODE_INT;   // codeLoad low here
        endcase

        case (excEvent.kind)
            excFetchAddrErr: begin
                commit.badVAddrLoad  = 1'b1;
                commit.badVAddrValue = excEvent.pc;
            end
            excLoadAddrErr, excStoreAddrErr: begin
                commit.badVAddrLoad  = 1'b1;
                commit.badVAddrValue = excEvent.dataAddr;
            end
            default: commit.badVAddrLoad = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/cp0StatusCause.sv */
// Status and Cause registers of the CP0 core
// Merges software writes, exception commits, interrupt pins and the timer flag

`include "cp0_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module cp0StatusCause
    import cp0Pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  regWrite_t  regWrite,
    input  excCommit_t commit,
    input  logic [5:0] intr,
    input  logic       timerMatch,
    output cp0Word_u   statusWord,
    output cp0Word_u   causeWord,
    output logic       exl,
    output cp0View_t   view
);

    statusReg_t statusQ;
    causeReg_t  causeQ;
    cp0Word_u   wrWord;

    assign wrWord.raw = regWrite.data;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            statusQ <= statusReg_t'(`STATUS_RESET);
        end else begin
            if (regWrite.status) begin
                statusQ <= wrWord.status;
            end
            // Exception side overrides a same-cycle write
            if (commit.enter) begin
                statusQ.exl <= 1'b1;
            end else if (commit.eret) begin
                statusQ.exl <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            causeQ <= '0;
        end else begin
            causeQ.ip7to2 <= intr | {causeQ.ti, 5'b0};   // Timer on IP7
            if (regWrite.compare) begin
                causeQ.ti <= 1'b0;
            end else if (timerMatch) begin
                causeQ.ti <= 1'b1;
            end
            if (regWrite.cause) begin
                causeQ.ip1to0 <= wrWord.cause.ip1to0;
            end
            if (commit.epcLoad) begin
                causeQ.bd <= commit.bdValue;
            end
            if (commit.codeLoad) begin
                causeQ.excCode <= commit.excCode;
            end
            if (commit.ceLoad) begin
                causeQ.ce <= 2'd1;   // Only CP1 unusable is reported
            end
        end
    end

    always_comb begin
        statusWord.status = statusQ;
        causeWord.cause   = causeQ;
    end

    assign exl = statusQ.exl;

    always_comb begin
        view.bev = statusQ.bev;
        view.im  = statusQ.im;
        view.exl = statusQ.exl;
        view.ie  = statusQ.ie;
        view.ip  = {causeQ.ip7to2, causeQ.ip1to0};
        view.epc = '0;   // Filled in at top
    end

endmodule

`default_nettype wire

/* source/cp0ExcAddr.sv */
// EPC and BadVAddr registers of the CP0 core
// EPC takes commits ahead of software writes, BadVAddr only commits

`timescale 1ns/1ps
`default_nettype none

module cp0ExcAddr
    import cp0Pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  regWrite_t   regWrite,
    input  excCommit_t  commit,
    output logic [31:0] epc,
    output logic [31:0] badVAddr
);

    logic [31:0] epcQ;
    logic [31:0] badVAddrQ;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            epcQ <= '0;
        end else if (commit.epcLoad) begin
            epcQ <= commit.epcValue;
        end else if (regWrite.epc) begin
            epcQ <= regWrite.data;
        end
    end

    // Address errors only
    always_ff @(posedge clk) begin
        if (!rstN) begin
            badVAddrQ <= '0;
        end else if (commit.badVAddrLoad) begin
            badVAddrQ <= commit.badVAddrValue;
        end
    end

    assign epc      = epcQ;
    assign badVAddr = badVAddrQ;

endmodule

`default_nettype wire

/* source/cp0Timer.sv */
// Count and Compare timer of the CP0 core
// Count runs at half the clock rate and flags a match with Compare

`timescale 1ns/1ps
`default_nettype none

module cp0Timer
    import cp0Pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  regWrite_t   regWrite,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timerMatch
);

    logic        divQ;
    logic [31:0] countQ;
    logic [31:0] compareQ;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            divQ   <= 1'b0;
            countQ <= '0;
        end else if (regWrite.count) begin
            divQ   <= 1'b0;   // Restart the half-rate phase
            countQ <= regWrite.data;
        end else begin
            divQ <= ~divQ;
            if (divQ) begin
                countQ <= countQ + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            compareQ <= '0;
        end else if (regWrite.compare) begin
            compareQ <= regWrite.data;
        end
    end

    assign count      = countQ;
    assign compare    = compareQ;
    assign timerMatch = countQ == compareQ;

endmodule

`default_nettype wire

/* source/cp0Top.sv */
// Top level of the CP0 exception and timer core
// APB for software access, one exception event per cycle from the pipeline

`timescale 1ns/1ps
`default_nettype none

module cp0Top
    import cp0Pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  excEvent_t   excEvent,
    input  logic [5:0]  intr,
    output cp0View_t    view
);

    regWrite_t   regWrite;
    excCommit_t  commit;
    cp0Word_u    statusWord;
    cp0Word_u    causeWord;
    cp0View_t    scView;
    logic        exl;
    logic        timerMatch;
    logic [31:0] epc;
    logic [31:0] badVAddr;
    logic [31:0] count;
    logic [31:0] compare;

    cp0ApbPort u_apbPort (
        .clk(clk), .rstN(rstN),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .statusWord(statusWord), .causeWord(causeWord),
        .epc(epc), .badVAddr(badVAddr), .count(count), .compare(compare),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .regWrite(regWrite)
    );

    cp0ExcCtrl u_excCtrl (
        .excEvent(excEvent), .exl(exl), .commit(commit)
    );

    cp0StatusCause u_statusCause (
        .clk(clk), .rstN(rstN), .regWrite(regWrite), .commit(commit),
        .intr(intr), .timerMatch(timerMatch),
        .statusWord(statusWord), .causeWord(causeWord), .exl(exl), .view(scView)
    );

    cp0ExcAddr u_excAddr (
        .clk(clk), .rstN(rstN), .regWrite(regWrite), .commit(commit),
        .epc(epc), .badVAddr(badVAddr)
    );

    cp0Timer u_timer (
        .clk(clk), .rstN(rstN), .regWrite(regWrite),
        .count(count), .compare(compare), .timerMatch(timerMatch)
    );

    always_comb begin
        view     = scView;
        view.epc = epc;
    end

endmodule

`default_nettype wire

/* verification/cp0TbClock.sv */
// Clock and reset source for the CP0 testbench
// 8 ns clock, reset held low for the first 5 rising edges

`timescale 1ns/1ps
`default_nettype none

module cp0TbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        #1 rstN = 1'b1;   // Released just after an edge
    end

endmodule

`default_nettype wire

/* verification/cp0Tb.sv */
// Testbench of the CP0 core: APB register access, exception events, timer and interrupts
// Drives inputs 1 ns after the rising edge, samples on the falling edge

`include "cp0_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module cp0Tb
    import cp0Pkg::*;
();

    logic        clk;
    logic        rstN;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    excEvent_t   excEvent;
    logic [5:0]  intr;
    cp0View_t    view;

    integer      seed;
    int          checkCount;
    int          errCount;
    int          timeoutCount;
    int unsigned cycleNum;
    int unsigned lastReadCycle;   // Cycle of the last APB sample

    cp0TbClock u_clock (
        .clk(clk),
        .rstN(rstN)
    );

    cp0Top u_cp0Top (
        .clk(clk), .rstN(rstN),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .excEvent(excEvent), .intr(intr), .view(view)
    );

    // Tracks the timer divider, which restarts with reset
    always @(posedge clk) begin
        if (!rstN) begin
            cycleNum <= 0;
        end else begin
            cycleNum <= cycleNum + 1;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errCount++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkRange(input string name, input logic [31:0] lo,
                              input logic [31:0] hi, input logic [31:0] actual);
        checkCount++;
        assert (actual >= lo && actual <= hi) else begin
            errCount++;
            $display("Error %s: expected %0d to %0d, actual %0d", name, lo, hi, actual);
        end
    endtask

    // One setup and one access cycle, called 1 ns after a rising edge
    task automatic apbTransfer(input logic write, input logic [4:0] regNum,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        int waitCycles;
        paddr   = {5'd0, regNum, 2'b00};
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable    = 1'b1;
        waitCycles = 0;
        @(negedge clk);
        while (!pready && waitCycles < 16) begin
            waitCycles++;
            @(negedge clk);
        end
        if (!pready) begin
            timeoutCount++;
            $display("APB transfer to register %0d never saw pready", regNum);
        end
        rdata         = prdata;
        err           = pslverr;
        lastReadCycle = cycleNum;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbWrite(input logic [4:0] regNum, input logic [31:0] data,
                            output logic err);
        logic [31:0] unused;
        apbTransfer(1'b1, regNum, data, unused, err);
    endtask

    task automatic apbRead(input logic [4:0] regNum, output logic [31:0] data,
                           output logic err);
        apbTransfer(1'b0, regNum, 32'd0, data, err);
    endtask

    // Event is present for one edge only
    task automatic sendEvent(input excKind_e kind, input logic [31:0] pc,
                             input logic inDelaySlot, input logic [31:0] dataAddr);
        excEvent.kind        = kind;
        excEvent.pc          = pc;
        excEvent.inDelaySlot = inDelaySlot;
        excEvent.dataAddr    = dataAddr;
        @(posedge clk);
        #1;
        excEvent = '0;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] wr;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] epcWritten;
        logic [31:0] compareWritten;
        logic [31:0] savedEpc;
        logic [31:0] countA;
        logic [31:0] half;
        logic        err;
        int unsigned cycA;
        int          waitCycles;
        logic [5:0]  intrValue;

        seed         = 54595;
        checkCount   = 0;
        errCount     = 0;
        timeoutCount = 0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        excEvent     = '0;
        intr         = '0;

        waitCycles = 0;
        while (rstN !== 1'b1 && waitCycles < 20) begin
            @(posedge clk);
            waitCycles++;
        end
        if (rstN !== 1'b1) begin
            timeoutCount++;
            $display("Reset was never released");
        end
        @(posedge clk);
        #1;

        // Reset values
        apbRead(`CP0_REG_STATUS, rd, err);
        checkValue("reset status", `STATUS_RESET, rd);
        // Count and Compare both start at zero, so TI rises at once and reaches IP7
        apbRead(`CP0_REG_CAUSE, rd, err);
        checkValue("reset cause", 32'h4000_8000, rd);
        apbRead(`CP0_REG_EPC, rd, err);
        checkValue("reset epc", 32'd0, rd);
        apbRead(`CP0_REG_COUNT, rd, err);
        half = lastReadCycle / 2;
        checkRange("reset count", (half > 0) ? half - 1 : 0, half + 1, rd);
        checkValue("reset exl", 32'd0, view.exl);
        checkValue("reset bev", 32'd1, view.bev);

        // Write and read back; Compare first so TI is gone before Cause is read
        compareWritten = $random(seed);
        apbWrite(`CP0_REG_COMPARE, compareWritten, err);
        checkValue("compare write pslverr", 32'd0, err);
        apbRead(`CP0_REG_COMPARE, rd, err);
        checkValue("compare readback", compareWritten, rd);
        wr = $random(seed);
        apbWrite(`CP0_REG_STATUS, wr, err);
        apbRead(`CP0_REG_STATUS, rd, err);
        checkValue("status readback", wr & `STATUS_WR_MASK, rd);
        checkValue("status view", {wr[22], wr[15:8], wr[0]}, {view.bev, view.im, view.ie});
        wr = $random(seed);
        apbWrite(`CP0_REG_CAUSE, wr, err);
        apbRead(`CP0_REG_CAUSE, rd, err);
        checkValue("cause readback", wr & `CAUSE_WR_MASK, rd);
        epcWritten = $random(seed);
        apbWrite(`CP0_REG_EPC, epcWritten, err);
        apbRead(`CP0_REG_EPC, rd, err);
        checkValue("epc readback", epcWritten, rd);
        apbWrite(`CP0_REG_STATUS, `STATUS_RESET, err);   // EXL clear again

        // Illegal accesses
        apbWrite(`CP0_REG_BADVADDR, $random(seed), err);
        checkValue("badvaddr write pslverr", 32'd1, err);
        apbRead(`CP0_REG_BADVADDR, rd, err);
        checkValue("badvaddr unchanged", 32'd0, rd);
        checkValue("badvaddr read pslverr", 32'd0, err);
        apbWrite(5'd3, $random(seed), err);
        checkValue("unmapped write pslverr", 32'd1, err);
        apbRead(5'd3, rd, err);
        checkValue("unmapped read data", 32'd0, rd);
        checkValue("unmapped read pslverr", 32'd1, err);
        apbRead(`CP0_REG_EPC, rd, err);
        checkValue("epc after bad writes", epcWritten, rd);
        apbRead(`CP0_REG_STATUS, rd, err);
        checkValue("status after bad writes", `STATUS_RESET, rd);
        apbRead(`CP0_REG_COMPARE, rd, err);
        checkValue("compare after bad writes", compareWritten, rd);

        // Exception entry and return
        pc = $random(seed) & 32'hFFFF_FFFC;
        sendEvent(excSyscall, pc, 1'b1, 32'd0);
        checkValue("syscall exl", 32'd1, view.exl);
        savedEpc = pc - 32'd4;   // Branch before the delay slot
        apbRead(`CP0_REG_EPC, rd, err);
        checkValue("syscall epc", savedEpc, rd);
        checkValue("syscall view epc", savedEpc, view.epc);
        apbRead(`CP0_REG_CAUSE, rd, err);
        checkValue("syscall bd", 32'd1, rd[31]);
        checkValue("syscall code", `EXC_CODE_SYS, rd[6:2]);
        sendEvent(excOverflow, pc + 32'h100, 1'b0, 32'd0);
        apbRead(`CP0_REG_EPC, rd, err);
        checkValue("nested epc", savedEpc, rd);
        apbRead(`CP0_REG_CAUSE, rd, err);
        checkValue("nested code", `EXC_CODE_OV, rd[6:2]);
        checkValue("nested bd", 32'd1, rd[31]);
        sendEvent(excEret, 32'd0, 1'b0, 32'd0);
        checkValue("eret exl", 32'd0, view.exl);
        apbRead(`CP0_REG_STATUS, rd, err);
        checkValue("eret status", `STATUS_RESET, rd);
        sendEvent(excCopUnusable, pc, 1'b0, 32'd0);
        apbRead(`CP0_REG_CAUSE, rd, err);
        checkValue("cpu ce", 32'd1, rd[29:28]);
        checkValue("cpu code", `EXC_CODE_CPU, rd[6:2]);
        sendEvent(excEret, 32'd0, 1'b0, 32'd0);

        // Address errors
        pc = $random(seed);
        sendEvent(excFetchAddrErr, pc, 1'b0, $random(seed));
        apbRead(`CP0_REG_BADVADDR, rd, err);
        checkValue("fetch badvaddr", pc, rd);
        apbRead(`CP0_REG_CAUSE, rd, err);
        checkValue("fetch code", `EXC_CODE_ADEL, rd[6:2]);
        apbRead(`CP0_REG_EPC, rd, err);
        checkValue("fetch epc", pc, rd);
        sendEvent(excEret, 32'd0, 1'b0, 32'd0);
        addr = $random(seed);
        sendEvent(excStoreAddrErr, $random(seed), 1'b0, addr);
        apbRead(`CP0_REG_BADVADDR, rd, err);
        checkValue("store badvaddr", addr, rd);
        apbRead(`CP0_REG_CAUSE, rd, err);
        checkValue("store code", `EXC_CODE_ADES, rd[6:2]);
        sendEvent(excEret, 32'd0, 1'b0, 32'd0);

        // Timer
        apbWrite(`CP0_REG_COUNT, 32'd0, err);
        apbWrite(`CP0_REG_COMPARE, 32'd20, err);
        waitCycles = 0;
        while (!view.ip[7] && waitCycles < 200) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!view.ip[7]) begin
            timeoutCount++;
            $display("Timer interrupt never showed up on IP7");
        end
        @(posedge clk);
        #1;
        apbRead(`CP0_REG_CAUSE, rd, err);
        checkValue("timer ti", 32'd1, rd[30]);
        apbRead(`CP0_REG_COUNT, countA, err);
        checkRange("count after match", 32'd20, 32'hFFFF_FFFF, countA);
        cycA = lastReadCycle;
        repeat (30) @(posedge clk);
        #1;
        apbRead(`CP0_REG_COUNT, rd, err);
        half = (lastReadCycle - cycA) / 2;
        checkRange("count rate", countA + half - 1, countA + half + 1, rd);
        apbWrite(`CP0_REG_COMPARE, 32'hFFFF_0000, err);
        apbRead(`CP0_REG_CAUSE, rd, err);
        checkValue("ti cleared", 32'd0, rd[30]);
        checkValue("ip7 cleared", 32'd0, view.ip[7]);

        // Hardware interrupts, one cycle of latency
        intrValue = $random(seed);
        if (intrValue == 6'd0) begin
            intrValue = 6'h15;
        end
        intr = intrValue;
        @(negedge clk);
        checkValue("intr before edge", 32'd0, view.ip[7:2]);
        @(posedge clk);
        #1;
        checkValue("intr in view", intrValue, view.ip[7:2]);
        apbRead(`CP0_REG_CAUSE, rd, err);
        checkValue("intr in cause", intrValue, rd[15:10]);
        intr = '0;

        $display("Checks run: %0d, errors: %0d, timeouts: %0d",
                 checkCount, errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/cp0Pkg.sv
source/cp0ApbPort.sv
source/cp0ExcCtrl.sv
source/cp0StatusCause.sv
source/cp0ExcAddr.sv
source/cp0Timer.sv
source/cp0Top.sv
verification/cp0TbClock.sv
verification/cp0Tb.sv

/* Bender.yml */
package:
  name: cp0

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cp0Pkg.sv
      - source/cp0ApbPort.sv
      - source/cp0ExcCtrl.sv
      - source/cp0StatusCause.sv
      - source/cp0ExcAddr.sv
      - source/cp0Timer.sv
      - source/cp0Top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/cp0TbClock.sv
      - verification/cp0Tb.sv
